// ==== noc_sa_settings.svh ====
// ==========================================================
// Switch allocator settings
// Port count, field widths and the no-grant select code
// ==========================================================
`ifndef NOC_SA_SETTINGS_SVH
`define NOC_SA_SETTINGS_SVH

// Router ports: north, east, south, west, local
`define NOC_SA_NUM_PORTS 5

// Width of a port index and of an output select
`define NOC_SA_PORT_BITS 3

// Field widths carried with each buffer request
`define NOC_SA_PKT_ID_BITS 7
`define NOC_SA_FLIT_BITS 3

// Output select when no input wins
`define NOC_SA_NO_GRANT 3'd7

`endif

// ==== noc_sa_pkg.sv ====
// ==========================================================
// Switch allocator package
// Flit type and port direction encodings
// ==========================================================
`default_nettype none

`include "noc_sa_settings.svh"

package noc_sa_pkg;

	// Codes other than head and tail behave like body
	typedef enum logic [`NOC_SA_FLIT_BITS-1:0] {
		FLIT_HEAD = 3'd0,
		FLIT_BODY = 3'd1,
		FLIT_TAIL = 3'd2
	} flit_type_e;

	// Route direction and input index share one encoding
	typedef enum logic [`NOC_SA_PORT_BITS-1:0] {
		PORT_NORTH = 3'd0,
		PORT_EAST  = 3'd1,
		PORT_SOUTH = 3'd2,
		PORT_WEST  = 3'd3,
		PORT_LOCAL = 3'd4
	} port_e;

endpackage

`default_nettype wire

// ==== noc_sa_route_filter.sv ====
// ==========================================================
// Route filter for one input buffer
// Turns the route direction into one output request, masked by locks
// ==========================================================
`timescale 1ns/1ps
`default_nettype none

`include "noc_sa_settings.svh"

module noc_sa_route_filter import noc_sa_pkg::*; (
	input  logic                        buf_request,
	input  port_e                       route_dir,
	input  logic [`NOC_SA_PKT_ID_BITS-1:0] pkt_id,

	// Lock state fed back from every output arbiter
	input  logic [`NOC_SA_NUM_PORTS-1:0] port_locked,
	input  logic [`NOC_SA_NUM_PORTS-1:0][`NOC_SA_PKT_ID_BITS-1:0] locked_pkt_id,

	// One bit per output port
	output logic [`NOC_SA_NUM_PORTS-1:0] out_request
);

	logic [`NOC_SA_NUM_PORTS-1:0] dir_hit;
	logic [`NOC_SA_NUM_PORTS-1:0] owner_ok;

	// ==========================================================
	// Direction decode
	// ==========================================================
	// Codes above local match no bit and so raise nothing
	always_comb begin
		dir_hit = '0;
		for (int o = 0; o < `NOC_SA_NUM_PORTS; o++) begin
			if (route_dir == port_e'(o))
				dir_hit[o] = 1'b1;
		end
	end

	// ==========================================================
	// Lock mask
	// ==========================================================
	// A locked output only accepts the packet that owns it
	always_comb begin
		for (int o = 0; o < `NOC_SA_NUM_PORTS; o++) begin
			owner_ok[o] = !port_locked[o] || (locked_pkt_id[o] == pkt_id);
		end
	end

	always_comb begin
		for (int o = 0; o < `NOC_SA_NUM_PORTS; o++) begin
			out_request[o] = buf_request && dir_hit[o] && owner_ok[o];
		end
	end

endmodule

`default_nettype wire

// ==== noc_sa_output_arbiter.sv ====
// ==========================================================
// Output port arbiter
// Round-robin winner pick plus wormhole lock to one packet
// ==========================================================
`timescale 1ns/1ps
`default_nettype none

`include "noc_sa_settings.svh"

module noc_sa_output_arbiter import noc_sa_pkg::*; (
	input  logic clk,
	input  logic rst,

	// Filtered requests from all inputs towards this output
	input  logic [`NOC_SA_NUM_PORTS-1:0] request,

	// Flit fields of every input buffer
	input  flit_type_e [`NOC_SA_NUM_PORTS-1:0] flit_type,
	input  logic [`NOC_SA_NUM_PORTS-1:0][`NOC_SA_PKT_ID_BITS-1:0] pkt_id,

	// Winning input index, or the no-grant code
	output logic [`NOC_SA_PORT_BITS-1:0] out_select,

	// Current owner of this output
	output logic                         port_locked,
	output logic [`NOC_SA_PKT_ID_BITS-1:0] locked_pkt_id
);

	// Index of the input that won most recently
	logic [`NOC_SA_PORT_BITS-1:0] last_grant;

	logic                            win_valid;
	logic [`NOC_SA_PORT_BITS-1:0]    win_index;
	flit_type_e                      win_flit;
	logic [`NOC_SA_PKT_ID_BITS-1:0]  win_pkt_id;

	logic lock_set;
	logic lock_clear;

	// ==========================================================
	// Round-robin search
	// ==========================================================
	// Start one past the last winner and wrap, so the last
	// winner itself is tried last
	always_comb begin
		int idx;
		win_valid  = 1'b0;
		win_index  = `NOC_SA_NO_GRANT;
		win_flit   = FLIT_BODY;
		win_pkt_id = '0;
		for (int k = 1; k <= `NOC_SA_NUM_PORTS; k++) begin
			idx = int'(last_grant) + k;
			if (idx >= `NOC_SA_NUM_PORTS)
				idx = idx - `NOC_SA_NUM_PORTS;
			if (!win_valid && request[idx]) begin
				win_valid  = 1'b1;
				win_index  = `NOC_SA_PORT_BITS'(idx);
				win_flit   = flit_type[idx];
				win_pkt_id = pkt_id[idx];
			end
		end
	end

	assign out_select = win_index;

	// ==========================================================
	// Wormhole lock
	// ==========================================================
	// Head flit claims a free output
	assign lock_set = !port_locked && win_valid && (win_flit == FLIT_HEAD);

	// Tail of the owning packet releases it
	assign lock_clear = port_locked && win_valid && (win_flit == FLIT_TAIL) &&
		(win_pkt_id == locked_pkt_id);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			port_locked <= 1'b0;
		end else begin
			if (lock_set)
				port_locked <= 1'b1;
			else if (lock_clear)
				port_locked <= 1'b0;
		end
	end

	// Owner id taken from the head flit that locks the output
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			locked_pkt_id <= '0;
		end else if (lock_set) begin
			locked_pkt_id <= win_pkt_id;
		end
	end

	// ==========================================================
	// Pointer update
	// ==========================================================
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			last_grant <= PORT_NORTH;
		end else if (win_valid) begin
			last_grant <= win_index;
		end
	end

endmodule

`default_nettype wire

// ==== noc_sa_top.sv ====
// ==========================================================
// Five-port wormhole crossbar switch allocator
// Route filters per input, round-robin arbiters per output
// ==========================================================
`timescale 1ns/1ps
`default_nettype none

`include "noc_sa_settings.svh"

module noc_sa_top import noc_sa_pkg::*; (
	input  logic clk,
	input  logic rst,

	// Input buffer side, indexed by port_e
	input  logic [`NOC_SA_NUM_PORTS-1:0] buf_request,
	input  port_e [`NOC_SA_NUM_PORTS-1:0] route_dir,
	input  flit_type_e [`NOC_SA_NUM_PORTS-1:0] flit_type,
	input  logic [`NOC_SA_NUM_PORTS-1:0][`NOC_SA_PKT_ID_BITS-1:0] pkt_id,

	// Grant back to each input buffer
	output logic [`NOC_SA_NUM_PORTS-1:0] buf_grant,

	// Crossbar select per output port
	output logic [`NOC_SA_NUM_PORTS-1:0][`NOC_SA_PORT_BITS-1:0] out_select
);

	// Row per input, one bit per output
	logic [`NOC_SA_NUM_PORTS-1:0][`NOC_SA_NUM_PORTS-1:0] req_row;

	// Row per output, one bit per input
	logic [`NOC_SA_NUM_PORTS-1:0][`NOC_SA_NUM_PORTS-1:0] req_col;

	// Lock feedback from the arbiters
	logic [`NOC_SA_NUM_PORTS-1:0] port_locked;
	logic [`NOC_SA_NUM_PORTS-1:0][`NOC_SA_PKT_ID_BITS-1:0] locked_pkt_id;

	// ==========================================================
	// Input side filters
	// ==========================================================
	for (genvar i = 0; i < `NOC_SA_NUM_PORTS; i++) begin : g_filter
		noc_sa_route_filter u_filter (
			.buf_request   (buf_request[i]),
			.route_dir     (route_dir[i]),
			.pkt_id        (pkt_id[i]),
			.port_locked   (port_locked),
			.locked_pkt_id (locked_pkt_id),
			.out_request   (req_row[i])
		);
	end

	// Transpose so each arbiter sees its own column
	always_comb begin
		for (int o = 0; o < `NOC_SA_NUM_PORTS; o++) begin
			for (int i = 0; i < `NOC_SA_NUM_PORTS; i++) begin
				req_col[o][i] = req_row[i][o];
			end
		end
	end

	// ==========================================================
	// Output side arbiters
	// ==========================================================
	for (genvar o = 0; o < `NOC_SA_NUM_PORTS; o++) begin : g_arbiter
		noc_sa_output_arbiter u_arbiter (
			.clk           (clk),
			.rst           (rst),
			.request       (req_col[o]),
			.flit_type     (flit_type),
			.pkt_id        (pkt_id),
			.out_select    (out_select[o]),
			.port_locked   (port_locked[o]),
			.locked_pkt_id (locked_pkt_id[o])
		);
	end

	// ==========================================================
	// Grant merge
	// ==========================================================
	// An input is granted if any output picked it
	// A filter raises one bit at most, so one output at most picks an input
	always_comb begin
		buf_grant = '0;
		for (int i = 0; i < `NOC_SA_NUM_PORTS; i++) begin
			for (int o = 0; o < `NOC_SA_NUM_PORTS; o++) begin
				if (out_select[o] == `NOC_SA_PORT_BITS'(i))
					buf_grant[i] = 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== noc_sa_tb.sv ====
// ==========================================================
// Switch allocator testbench
// Directed tests for routing, round-robin, wormhole lock
// ==========================================================
`timescale 1ns/1ps
`default_nettype none

`include "noc_sa_settings.svh"

module noc_sa_tb import noc_sa_pkg::*; ();

	localparam int NP = `NOC_SA_NUM_PORTS;

	logic clk;
	logic rst;
	logic [NP-1:0] buf_request;
	port_e [NP-1:0] route_dir;
	flit_type_e [NP-1:0] flit_type;
	logic [NP-1:0][`NOC_SA_PKT_ID_BITS-1:0] pkt_id;
	logic [NP-1:0] buf_grant;
	logic [NP-1:0][`NOC_SA_PORT_BITS-1:0] out_select;

	integer seed;
	int errors;
	int checks;
	// Model of the round-robin pointer of the output under test
	int rr_ptr;

	noc_sa_top dut0 (
		.clk         (clk),
		.rst         (rst),
		.buf_request (buf_request),
		.route_dir   (route_dir),
		.flit_type   (flit_type),
		.pkt_id      (pkt_id),
		.buf_grant   (buf_grant),
		.out_select  (out_select)
	);

	always #50 clk = ~clk;

	// ==========================================================
	// Helpers
	// ==========================================================
	task check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		assert (act === exp) else begin
			errors++;
			$display("** Error at %0t: %s expected %0d, got %0d", $time, name, exp, act);
		end
	endtask

	task clear_inputs();
		for (int i = 0; i < NP; i++) begin
			buf_request[i] = 1'b0;
			route_dir[i] = PORT_NORTH;
			flit_type[i] = FLIT_BODY;
			pkt_id[i] = '0;
		end
	endtask

	task drive_flit(input int port, input int dir, input flit_type_e ft,
			input logic [`NOC_SA_PKT_ID_BITS-1:0] id);
		buf_request[port] = 1'b1;
		route_dir[port] = port_e'(dir);
		flit_type[port] = ft;
		pkt_id[port] = id;
	endtask

	task next_cycle();
		@(negedge clk);
	endtask

	// Combinational outputs settle after a drive
	task settle();
		#10;
	endtask

	task apply_reset();
		rst = 1'b1;
		clear_inputs();
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		rr_ptr = 0;
	endtask

	task wait_grant(input int port, input int limit, output int waited);
		waited = 0;
		while (buf_grant[port] !== 1'b1 && waited < limit) begin
			next_cycle();
			settle();
			waited++;
		end
		if (buf_grant[port] !== 1'b1) begin
			errors++;
			$display("Timed out after %0d cycles waiting for a grant on input %0d", limit, port);
		end
	endtask

	// One input routed and all others idle
	task check_lone(input int src, input int dir);
		for (int o = 0; o < NP; o++)
			check_eq($sformatf("out_select[%0d]", o),
				(o == dir) ? src : `NOC_SA_NO_GRANT, out_select[o]);
		check_eq("buf_grant", 1 << src, buf_grant);
	endtask

	// ==========================================================
	// Tests
	// ==========================================================
	task idle_after_reset();
		clear_inputs();
		settle();
		for (int o = 0; o < NP; o++)
			check_eq($sformatf("out_select[%0d]", o), `NOC_SA_NO_GRANT, out_select[o]);
		check_eq("buf_grant", 0, buf_grant);
	endtask

	task single_routing();
		logic [`NOC_SA_PKT_ID_BITS-1:0] id;
		for (int i = 0; i < NP; i++) begin
			for (int d = 0; d < NP; d++) begin
				id = $random(seed);
				next_cycle();
				clear_inputs();
				drive_flit(i, d, FLIT_HEAD, id);
				settle();
				check_lone(i, d);
				next_cycle();
				drive_flit(i, d, FLIT_TAIL, id);
				settle();
				check_lone(i, d);
			end
		end
		// Direction codes past local go nowhere
		for (int d = NP; d < 8; d++) begin
			next_cycle();
			clear_inputs();
			drive_flit(d - NP, d, FLIT_HEAD, id);
			settle();
			check_eq("buf_grant", 0, buf_grant);
			for (int o = 0; o < NP; o++)
				check_eq($sformatf("out_select[%0d]", o), `NOC_SA_NO_GRANT, out_select[o]);
		end
		next_cycle();
		clear_inputs();
	endtask

	task round_robin(input int target, input logic [NP-1:0] mask, input int packets);
		int left [NP];
		int win;
		int idx;
		int rounds;
		logic [`NOC_SA_PKT_ID_BITS-1:0] base;
		base = $random(seed);
		rounds = 0;
		for (int i = 0; i < NP; i++) begin
			left[i] = mask[i] ? packets : 0;
			rounds += left[i];
		end
		for (int r = 0; r < rounds; r++) begin
			win = -1;
			for (int k = 1; k <= NP; k++) begin
				idx = (rr_ptr + k) % NP;
				if (win < 0 && left[idx] > 0)
					win = idx;
			end
			next_cycle();
			clear_inputs();
			for (int i = 0; i < NP; i++)
				if (left[i] > 0)
					drive_flit(i, target, FLIT_HEAD, `NOC_SA_PKT_ID_BITS'(base + i));
			settle();
			check_eq($sformatf("out_select[%0d]", target), win, out_select[target]);
			check_eq($sformatf("buf_grant[%0d]", win), 1, buf_grant[win]);
			// Tail of the packet that now owns the output
			next_cycle();
			flit_type[win] = FLIT_TAIL;
			settle();
			check_eq($sformatf("out_select[%0d]", target), win, out_select[target]);
			check_eq($sformatf("buf_grant[%0d]", win), 1, buf_grant[win]);
			left[win]--;
			rr_ptr = win;
		end
		next_cycle();
		clear_inputs();
	endtask

	task wormhole_lock();
		int a;
		int b;
		int target;
		int waited;
		logic [`NOC_SA_PKT_ID_BITS-1:0] id_a;
		logic [`NOC_SA_PKT_ID_BITS-1:0] id_b;
		a = $unsigned($random(seed)) % NP;
		b = (a + 1 + $unsigned($random(seed)) % (NP - 1)) % NP;
		target = $unsigned($random(seed)) % NP;
		id_a = $random(seed);
		id_b = id_a ^ 7'h15;
		next_cycle();
		clear_inputs();
		drive_flit(a, target, FLIT_HEAD, id_a);
		settle();
		wait_grant(a, 4, waited);
		check_eq($sformatf("out_select[%0d]", target), a, out_select[target]);
		// B stays blocked through body flits and one idle gap
		for (int k = 0; k < 4; k++) begin
			next_cycle();
			if (k == 2)
				buf_request[a] = 1'b0;
			else
				drive_flit(a, target, FLIT_BODY, id_a);
			drive_flit(b, target, FLIT_HEAD, id_b);
			settle();
			check_eq($sformatf("buf_grant[%0d]", b), 0, buf_grant[b]);
			check_eq($sformatf("out_select[%0d]", target),
				(k == 2) ? `NOC_SA_NO_GRANT : a, out_select[target]);
		end
		next_cycle();
		drive_flit(a, target, FLIT_TAIL, id_a);
		settle();
		check_eq($sformatf("buf_grant[%0d]", a), 1, buf_grant[a]);
		check_eq($sformatf("buf_grant[%0d]", b), 0, buf_grant[b]);
		next_cycle();
		buf_request[a] = 1'b0;
		settle();
		wait_grant(b, 4, waited);
		check_eq("cycles before second packet grant", 0, waited);
		check_eq($sformatf("out_select[%0d]", target), b, out_select[target]);
		next_cycle();
		drive_flit(b, target, FLIT_TAIL, id_b);
		settle();
		check_eq($sformatf("out_select[%0d]", target), b, out_select[target]);
		next_cycle();
		clear_inputs();
	endtask

	task parallel_outputs();
		int shift;
		shift = $unsigned($random(seed)) % NP;
		next_cycle();
		clear_inputs();
		for (int i = 0; i < NP; i++)
			drive_flit(i, (i + shift) % NP, FLIT_HEAD, $random(seed));
		for (int f = 0; f < 2; f++) begin
			if (f == 1) begin
				next_cycle();
				for (int i = 0; i < NP; i++)
					flit_type[i] = FLIT_TAIL;
			end
			settle();
			check_eq("buf_grant", {NP{1'b1}}, buf_grant);
			for (int i = 0; i < NP; i++)
				check_eq($sformatf("out_select[%0d]", (i + shift) % NP), i,
					out_select[(i + shift) % NP]);
		end
		next_cycle();
		clear_inputs();
	endtask

	// ==========================================================
	// Sequence
	// ==========================================================
	initial begin
		int rr_target;
		clk = 1'b0;
		seed = 77721;
		errors = 0;
		checks = 0;
		apply_reset();
		idle_after_reset();
		single_routing();
		rr_target = $unsigned($random(seed)) % NP;
		apply_reset();
		round_robin(rr_target, 5'b11111, 1);
		round_robin(rr_target, 5'b01011, 2);
		wormhole_lock();
		parallel_outputs();
		next_cycle();
		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== noc_sa.f ====
+incdir+.
noc_sa_pkg.sv
noc_sa_route_filter.sv
noc_sa_output_arbiter.sv
noc_sa_top.sv
noc_sa_tb.sv
